/* Makefile */
VERILATOR ?= verilator
VFLAGS ?= --binary --timing --assert -Wno-fatal
TOP := spindle_tb
FILELIST := all.f
OBJ_DIR := obj_dir
SIM := $(OBJ_DIR)/V$(TOP)
SRCS := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: $(SIM)

$(SIM): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -qx 'PASS: all tests'

clean:
	rm -rf $(OBJ_DIR)

/* all.f */
verilog/spindle_pkg.sv
verilog/phase_sequencer.sv
verilog/fiber_dynamics.sv
verilog/afferent_encoder.sv
verilog/muscle_afferent_combiner.sv
verilog/spindle.sv
bench/spindle_asserts.sv
bench/spindle_tb.sv

/* bench/spindle_asserts.sv */
`timescale 1ns/100ps

module spindle_asserts (
	input  logic                  clk,
	input  logic                  reset,
	input  spindle_pkg::phase_t   phase,
	input  spindle_pkg::sample_t  ia_muscle,
	input  spindle_pkg::sample_t  ii_muscle
);

	// two-bit counter never lands on the unused code
	phase_in_range: assert property (@(posedge clk) disable iff (reset)
		phase != 2'd3)
		else $error("phase reached the unused value 3");

	bag1_then_bag2: assert property (@(posedge clk) disable iff (reset)
		phase == spindle_pkg::phase_bag1 |=> phase == spindle_pkg::phase_bag2)
		else $error("phase did not move from bag1 to bag2");

	bag2_then_chain: assert property (@(posedge clk) disable iff (reset)
		phase == spindle_pkg::phase_bag2 |=> phase == spindle_pkg::phase_chain)
		else $error("phase did not move from bag2 to chain");

	chain_then_bag1: assert property (@(posedge clk) disable iff (reset)
		phase == spindle_pkg::phase_chain |=> phase == spindle_pkg::phase_bag1)
		else $error("phase did not wrap from chain to bag1");

	// muscle outputs move only on the edge that closes a frame
	ia_frame_update: assert property (@(posedge clk) disable iff (reset)
		ia_muscle != $past(ia_muscle) |-> $past(phase) == spindle_pkg::phase_chain)
		else $error("ia_muscle changed outside the end of phase_chain");

	ii_frame_update: assert property (@(posedge clk) disable iff (reset)
		ii_muscle != $past(ii_muscle) |-> $past(phase) == spindle_pkg::phase_chain)
		else $error("ii_muscle changed outside the end of phase_chain");

endmodule

bind spindle spindle_asserts spindle_asserts_i (
	.clk(clk), .reset(reset), .phase(phase), .ia_muscle(ia_muscle), .ii_muscle(ii_muscle)
);

/* bench/spindle_tb.sv */
`timescale 1ns/100ps

module spindle_tb;

	localparam int clk_period = 8;
	localparam int reset_cycles = 8;
	localparam int cadence_cycles = 90;
	localparam int zero_cycles = 300;
	localparam int settle_cycles = 600;
	localparam int lag_cycles = 2000;
	// one reset per test plus every test window, with headroom
	localparam int watchdog_cycles = 5 * (reset_cycles + 2) + cadence_cycles + zero_cycles
		+ settle_cycles + lag_cycles + 500;

	localparam spindle_pkg::sample_t q_one = 32'sd65536;
	localparam spindle_pkg::sample_t q_half = 32'sd32768;
	localparam spindle_pkg::sample_t q_quarter = 32'sd16384;
	localparam spindle_pkg::sample_t q_thousand = 32'sd65536000;
	// rate ceiling in whole units
	localparam int rate_max_units = 10000;

	logic                 clk;
	logic                 reset;
	spindle_pkg::sample_t gamma_dyn;
	spindle_pkg::sample_t gamma_sta;
	spindle_pkg::sample_t lce;
	spindle_pkg::sample_t bag1_x0;
	spindle_pkg::sample_t bag2_ii_rate;
	spindle_pkg::sample_t ii_muscle;
	spindle_pkg::sample_t ia_muscle;

	int error_count;
	int tests_run;
	int tests_failed;

	spindle spindle_i (
		.clk(clk), .reset(reset), .gamma_dyn(gamma_dyn), .gamma_sta(gamma_sta), .lce(lce),
		.bag1_x0(bag1_x0), .bag2_ii_rate(bag2_ii_rate), .ii_muscle(ii_muscle),
		.ia_muscle(ia_muscle)
	);

	initial begin
		clk = 1'b0;
		forever #(clk_period / 2) clk = ~clk;
	end

	task automatic expect_value(input string name, input spindle_pkg::sample_t expected,
		input spindle_pkg::sample_t actual);
		if (actual !== expected) begin
			$display("ERR %s expected %h actual %h", name, expected, actual);
			error_count++;
		end
	endtask

	task automatic expect_outputs_zero();
		expect_value("bag1_x0", '0, bag1_x0);
		expect_value("bag2_ii_rate", '0, bag2_ii_rate);
		expect_value("ii_muscle", '0, ii_muscle);
		expect_value("ia_muscle", '0, ia_muscle);
	endtask

	task automatic close_test(input string name, input int start_errors);
		tests_run++;
		if (error_count == start_errors) begin
			$display("test %s: ok", name);
		end else begin
			tests_failed++;
			$display("test %s: failed with %0d errors", name, error_count - start_errors);
		end
	endtask

	task automatic apply_reset();
		@(negedge clk);
		reset = 1'b1;
		repeat (reset_cycles) @(negedge clk);
		reset = 1'b0;
	endtask

	task automatic test_reset_state();
		int start_errors;
		start_errors = error_count;
		@(negedge clk);
		reset = 1'b1;
		repeat (reset_cycles / 2) @(negedge clk);
		expect_outputs_zero();
		repeat (reset_cycles / 2) @(negedge clk);
		reset = 1'b0;
		expect_outputs_zero();
		// first edge after release, no muscle update yet
		@(negedge clk);
		expect_outputs_zero();
		close_test("reset_state", start_errors);
	endtask

	task automatic test_frame_cadence();
		int start_errors;
		int last_change;
		spindle_pkg::sample_t prev_ia;
		spindle_pkg::sample_t prev_ii;
		start_errors = error_count;
		lce = q_one;
		apply_reset();
		prev_ia = ia_muscle;
		prev_ii = ii_muscle;
		last_change = -spindle_pkg::fiber_count;
		for (int cycle = 0; cycle < cadence_cycles; cycle++) begin
			// lce wanders between 1.0 and 1.25
			lce = q_one + spindle_pkg::sample_t'($urandom % 32'd16384);
			@(negedge clk);
			if (ia_muscle !== prev_ia || ii_muscle !== prev_ii) begin
				if (cycle - last_change < spindle_pkg::fiber_count) begin
					$display("muscle outputs changed again only %0d cycles after the last change",
						cycle - last_change);
					error_count++;
				end
				last_change = cycle;
			end
			prev_ia = ia_muscle;
			prev_ii = ii_muscle;
		end
		if (last_change < 0) begin
			$display("muscle outputs never changed while lce was moving");
			error_count++;
		end
		close_test("frame_cadence", start_errors);
	endtask

	task automatic test_zero_clamp();
		int start_errors;
		start_errors = error_count;
		lce = '0;
		apply_reset();
		repeat (zero_cycles) @(negedge clk);
		expect_value("ia_muscle", '0, ia_muscle);
		expect_value("ii_muscle", '0, ii_muscle);
		expect_value("bag2_ii_rate", '0, bag2_ii_rate);
		close_test("zero_clamp", start_errors);
	endtask

	task automatic test_saturation();
		int start_errors;
		spindle_pkg::sample_t ia_expected;
		start_errors = error_count;
		// bag2 plus chain clamps, so both ia terms sit at the ceiling
		// a whole-unit ceiling leaves no fraction for the multiply to drop
		ia_expected = spindle_pkg::rate_max + spindle_pkg::ia_minor_weight * rate_max_units;
		apply_reset();
		lce = q_thousand;
		repeat (settle_cycles) @(negedge clk);
		expect_value("bag2_ii_rate", spindle_pkg::rate_max, bag2_ii_rate);
		expect_value("ii_muscle", spindle_pkg::rate_max + spindle_pkg::rate_max, ii_muscle);
		expect_value("ia_muscle", ia_expected, ia_muscle);
		close_test("saturation", start_errors);
	endtask

	task automatic test_activation_lag();
		int start_errors;
		int reach_cycle;
		logic fell;
		logic overshot;
		spindle_pkg::sample_t prev_x0;
		start_errors = error_count;
		gamma_dyn = '0;
		lce = q_one;
		apply_reset();
		gamma_dyn = q_half;
		prev_x0 = bag1_x0;
		reach_cycle = -1;
		fell = 1'b0;
		overshot = 1'b0;
		for (int cycle = 0; cycle < lag_cycles; cycle++) begin
			@(negedge clk);
			if (bag1_x0 < prev_x0 && !fell) begin
				$display("ERR bag1_x0 decreased, previous %h actual %h", prev_x0, bag1_x0);
				error_count++;
				fell = 1'b1;
			end
			if (bag1_x0 > q_half && !overshot) begin
				$display("ERR bag1_x0 limit %h actual %h", q_half, bag1_x0);
				error_count++;
				overshot = 1'b1;
			end
			if (reach_cycle < 0 && bag1_x0 > q_quarter) begin
				reach_cycle = cycle;
			end
			prev_x0 = bag1_x0;
		end
		if (reach_cycle < 0) begin
			$display("bag1_x0 never rose above 0.25 within %0d cycles", lag_cycles);
			error_count++;
		end
		close_test("activation_lag", start_errors);
	endtask

	initial begin
		void'($urandom(1));
		reset = 1'b1;
		gamma_dyn = '0;
		gamma_sta = '0;
		lce = '0;
		error_count = 0;
		tests_run = 0;
		tests_failed = 0;
		test_reset_state();
		test_frame_cadence();
		test_zero_clamp();
		test_saturation();
		test_activation_lag();
		$display("summary: %0d tests run, %0d failed, %0d errors",
			tests_run, tests_failed, error_count);
		if (error_count == 0 && tests_failed == 0) begin
			$display("PASS: all tests");
		end else begin
			$display("FAIL: see errors above");
		end
		$finish;
	end

	initial begin
		#(watchdog_cycles * clk_period);
		$display("watchdog expired before the tests finished");
		$display("FAIL: see errors above");
		$finish;
	end

endmodule

/* verilog/afferent_encoder.sv */
`timescale 1ns/100ps

module afferent_encoder (
	input  spindle_pkg::phase_t   phase,
	input  spindle_pkg::sample_t  lce,
	input  spindle_pkg::sample_t  x1_next,
	input  spindle_pkg::sample_t  ia_gain_sel,
	output spindle_pkg::sample_t  ia_rate,
	output spindle_pkg::sample_t  ii_rate
);

	// limit a wide rate to zero .. rate_max
	function automatic spindle_pkg::sample_t clamp_rate(input logic signed [63:0] v);
		logic signed [63:0] limit;
		limit = 64'(spindle_pkg::rate_max);
		if (v < 0) begin
			return '0;
		end
		if (v > limit) begin
			return spindle_pkg::rate_max;
		end
		return v[31:0];
	endfunction

	spindle_pkg::sample_t stretch;
	spindle_pkg::sample_t ii_inner;
	logic signed [63:0]   ia_wide;
	logic signed [63:0]   ii_wide;

	// sensory region stretch
	assign stretch = lce - x1_next - spindle_pkg::lsr0;

	assign ia_wide = spindle_pkg::fx_mul_wide(ia_gain_sel, stretch);

	// secondary ending sees both the sensory and polar regions
	assign ii_inner = spindle_pkg::fx_mul(spindle_pkg::c0, stretch)
		+ spindle_pkg::fx_mul(spindle_pkg::c3, lce - stretch - spindle_pkg::c6);
	assign ii_wide = spindle_pkg::fx_mul_wide(spindle_pkg::ii_gain, ii_inner);

	assign ia_rate = clamp_rate(ia_wide);
	assign ii_rate = clamp_rate(ii_wide);

endmodule

/* verilog/fiber_dynamics.sv */
`timescale 1ns/100ps

module fiber_dynamics (
	input  logic                  clk,
	input  logic                  reset,
	input  spindle_pkg::phase_t   phase,
	input  spindle_pkg::sample_t  lce,
	input  spindle_pkg::sample_t  activation,
	input  spindle_pkg::sample_t  tau_recip_sel,
	input  spindle_pkg::sample_t  bdamp_sel,
	input  spindle_pkg::sample_t  b0_sel,
	input  spindle_pkg::sample_t  f_coef_sel,
	input  spindle_pkg::sample_t  ksr_kpr_sel,
	output spindle_pkg::sample_t  x1_next,
	output spindle_pkg::sample_t  bag1_x0
);

	// state bank, one entry per fiber
	spindle_pkg::sample_t x0_bank [spindle_pkg::fiber_count];
	spindle_pkg::sample_t x1_bank [spindle_pkg::fiber_count];
	spindle_pkg::sample_t x2_bank [spindle_pkg::fiber_count];
	spindle_pkg::sample_t dx0_bank [spindle_pkg::fiber_count];
	spindle_pkg::sample_t dx1_bank [spindle_pkg::fiber_count];
	spindle_pkg::sample_t dx2_bank [spindle_pkg::fiber_count];

	logic                 served_valid;
	logic                 is_chain;
	spindle_pkg::phase_t  idx;
	spindle_pkg::sample_t x0_cur, x1_cur, x2_cur;
	spindle_pkg::sample_t x0_hat, x1_hat, x2_hat;
	spindle_pkg::sample_t x0_eff, css, threshold, x1_excess;
	spindle_pkg::sample_t damp, force_term, net_force;
	spindle_pkg::sample_t dx0, dx1, dx2;
	spindle_pkg::sample_t x0_new, x2_new;

	assign served_valid = (phase <= spindle_pkg::phase_chain);
	assign idx = served_valid ? phase : spindle_pkg::phase_bag1;
	assign is_chain = (phase == spindle_pkg::phase_chain);

	assign x0_cur = x0_bank[idx];
	assign x1_cur = x1_bank[idx];
	assign x2_cur = x2_bank[idx];

	// predictor from the previous derivative
	assign x0_hat = x0_cur + (dx0_bank[idx] >>> spindle_pkg::dt_shift);
	assign x1_hat = x1_cur + (dx1_bank[idx] >>> spindle_pkg::dt_shift);
	assign x2_hat = x2_cur + (dx2_bank[idx] >>> spindle_pkg::dt_shift);

	always_comb begin
		// chain has no state 0 lag, activation stands in for it
		x0_eff = is_chain ? activation : x0_hat;
		dx0 = is_chain ? '0 : spindle_pkg::fx_mul(activation - x0_hat, tau_recip_sel);
		dx1 = x2_hat;

		// length threshold, zero below rldfv
		x1_excess = x1_hat - spindle_pkg::rldfv;
		threshold = x1_excess[31] ? '0 : x1_excess;

		// copysign stands in for the smooth velocity sign
		css = x2_hat[31] ? -spindle_pkg::fx_one : spindle_pkg::fx_one;
		damp = spindle_pkg::fx_mul(css, spindle_pkg::fx_mul(bdamp_sel, x0_eff) + b0_sel);
		damp = spindle_pkg::fx_mul(damp, threshold);
		force_term = spindle_pkg::fx_mul(f_coef_sel, x0_eff);

		net_force = spindle_pkg::fx_mul(spindle_pkg::ksr, lce)
			- spindle_pkg::fx_mul(ksr_kpr_sel, x1_hat);
		net_force = net_force - damp - force_term;
		net_force = net_force - spindle_pkg::ksr_lsr0 + spindle_pkg::kpr_lpr0;
		dx2 = spindle_pkg::fx_mul(spindle_pkg::inv_mass, net_force);
	end

	// euler step from the stored state
	assign x0_new = x0_cur + (dx0 >>> spindle_pkg::dt_shift);
	assign x1_next = x1_cur + (dx1 >>> spindle_pkg::dt_shift);
	assign x2_new = x2_cur + (dx2 >>> spindle_pkg::dt_shift);

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			for (int i = 0; i < spindle_pkg::fiber_count; i++) begin
				x0_bank[i] <= '0;
				x1_bank[i] <= spindle_pkg::x1_reset;
				x2_bank[i] <= '0;
				dx0_bank[i] <= '0;
				dx1_bank[i] <= '0;
				dx2_bank[i] <= '0;
			end
		end else if (served_valid) begin
			x0_bank[idx] <= x0_new;
			x1_bank[idx] <= x1_next;
			x2_bank[idx] <= x2_new;
			dx0_bank[idx] <= dx0;
			dx1_bank[idx] <= dx1;
			dx2_bank[idx] <= dx2;
		end
	end

	assign bag1_x0 = x0_bank[spindle_pkg::phase_bag1];

endmodule

/* verilog/muscle_afferent_combiner.sv */
`timescale 1ns/100ps

module muscle_afferent_combiner (
	input  logic                  clk,
	input  logic                  reset,
	input  spindle_pkg::phase_t   phase,
	input  spindle_pkg::sample_t  ia_rate,
	input  spindle_pkg::sample_t  ii_rate,
	output spindle_pkg::sample_t  bag2_ii_rate,
	output spindle_pkg::sample_t  ia_muscle,
	output spindle_pkg::sample_t  ii_muscle
);

	spindle_pkg::sample_t bag1_ia;
	spindle_pkg::sample_t bag2_ia;
	spindle_pkg::sample_t bag2chain_sum;
	spindle_pkg::sample_t bag2chain_ia;
	spindle_pkg::sample_t ia_larger;
	spindle_pkg::sample_t ia_smaller;

	// bag2 plus chain, held to the rate ceiling
	assign bag2chain_sum = bag2_ia + ia_rate;
	assign bag2chain_ia = (bag2chain_sum > spindle_pkg::rate_max) ?
		spindle_pkg::rate_max : bag2chain_sum;

	assign ia_larger = (bag1_ia > bag2chain_ia) ? bag1_ia : bag2chain_ia;
	assign ia_smaller = (bag1_ia > bag2chain_ia) ? bag2chain_ia : bag1_ia;

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			bag1_ia <= '0;
			bag2_ia <= '0;
			bag2_ii_rate <= '0;
			ia_muscle <= '0;
			ii_muscle <= '0;
		end else begin
			case (phase)
				spindle_pkg::phase_bag1: bag1_ia <= ia_rate;
				spindle_pkg::phase_bag2: begin
					bag2_ia <= ia_rate;
					bag2_ii_rate <= ii_rate;
				end
				// chain rates arrive live, muscle outputs close the frame
				spindle_pkg::phase_chain: begin
					ii_muscle <= bag2_ii_rate + ii_rate;
					ia_muscle <= ia_larger
						+ spindle_pkg::fx_mul(spindle_pkg::ia_minor_weight, ia_smaller);
				end
				default: begin
				end
			endcase
		end
	end

endmodule

/* verilog/phase_sequencer.sv */
`timescale 1ns/100ps

module phase_sequencer (
	input  logic                  clk,
	input  logic                  reset,
	input  spindle_pkg::sample_t  gamma_dyn,
	input  spindle_pkg::sample_t  gamma_sta,
	output spindle_pkg::phase_t   phase,
	output spindle_pkg::sample_t  activation,
	output spindle_pkg::sample_t  tau_recip_sel,
	output spindle_pkg::sample_t  bdamp_sel,
	output spindle_pkg::sample_t  b0_sel,
	output spindle_pkg::sample_t  f_coef_sel,
	output spindle_pkg::sample_t  ksr_kpr_sel,
	output spindle_pkg::sample_t  ia_gain_sel
);

	// modulo-3 frame counter
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			phase <= spindle_pkg::phase_bag1;
		end else if (phase == spindle_pkg::phase_chain) begin
			phase <= spindle_pkg::phase_bag1;
		end else begin
			phase <= phase + 2'd1;
		end
	end

	// dynamic gamma drives bag1 only
	assign activation = (phase == spindle_pkg::phase_bag1) ? gamma_dyn : gamma_sta;

	always_comb begin
		tau_recip_sel = spindle_pkg::tau_recip[phase];
		bdamp_sel = spindle_pkg::bdamp[phase];
		b0_sel = spindle_pkg::b0[phase];
		f_coef_sel = spindle_pkg::f_coef[phase];
		ksr_kpr_sel = spindle_pkg::ksr_kpr[phase];
		ia_gain_sel = spindle_pkg::ia_gain[phase];
	end

endmodule

/* verilog/spindle.sv */
`timescale 1ns/100ps

module spindle (
	input  logic                  clk,
	input  logic                  reset,
	input  spindle_pkg::sample_t  gamma_dyn,
	input  spindle_pkg::sample_t  gamma_sta,
	input  spindle_pkg::sample_t  lce,
	output spindle_pkg::sample_t  bag1_x0,
	output spindle_pkg::sample_t  bag2_ii_rate,
	output spindle_pkg::sample_t  ii_muscle,
	output spindle_pkg::sample_t  ia_muscle
);

	spindle_pkg::phase_t  phase;
	spindle_pkg::sample_t activation;
	spindle_pkg::sample_t tau_recip_sel;
	spindle_pkg::sample_t bdamp_sel;
	spindle_pkg::sample_t b0_sel;
	spindle_pkg::sample_t f_coef_sel;
	spindle_pkg::sample_t ksr_kpr_sel;
	spindle_pkg::sample_t ia_gain_sel;
	spindle_pkg::sample_t x1_next;
	spindle_pkg::sample_t ia_rate;
	spindle_pkg::sample_t ii_rate;

	phase_sequencer sequencer_i (
		.clk(clk), .reset(reset), .gamma_dyn(gamma_dyn), .gamma_sta(gamma_sta),
		.phase(phase), .activation(activation), .tau_recip_sel(tau_recip_sel),
		.bdamp_sel(bdamp_sel), .b0_sel(b0_sel), .f_coef_sel(f_coef_sel),
		.ksr_kpr_sel(ksr_kpr_sel), .ia_gain_sel(ia_gain_sel)
	);

	fiber_dynamics dynamics_i (
		.clk(clk), .reset(reset), .phase(phase), .lce(lce), .activation(activation),
		.tau_recip_sel(tau_recip_sel), .bdamp_sel(bdamp_sel), .b0_sel(b0_sel),
		.f_coef_sel(f_coef_sel), .ksr_kpr_sel(ksr_kpr_sel),
		.x1_next(x1_next), .bag1_x0(bag1_x0)
	);

	afferent_encoder encoder_i (
		.phase(phase), .lce(lce), .x1_next(x1_next), .ia_gain_sel(ia_gain_sel),
		.ia_rate(ia_rate), .ii_rate(ii_rate)
	);

	muscle_afferent_combiner combiner_i (
		.clk(clk), .reset(reset), .phase(phase), .ia_rate(ia_rate), .ii_rate(ii_rate),
		.bag2_ii_rate(bag2_ii_rate), .ia_muscle(ia_muscle), .ii_muscle(ii_muscle)
	);

endmodule

/* verilog/spindle_pkg.sv */
package spindle_pkg;

	// Q16.16 signed fixed point
	typedef logic signed [31:0] sample_t;
	typedef logic [1:0] phase_t;

	localparam int frac_bits = 16;
	// euler step of 2^-12 s
	localparam int dt_shift = 12;
	localparam int fiber_count = 3;

	localparam phase_t phase_bag1 = 2'd0;
	localparam phase_t phase_bag2 = 2'd1;
	localparam phase_t phase_chain = 2'd2;

	localparam sample_t fx_one = 32'sd65536;

	// per-fiber tables in bag1, bag2, chain order
	localparam sample_t tau_recip [fiber_count] = '{32'sd439812, 32'sd319685, 32'sd0};
	localparam sample_t bdamp [fiber_count] = '{32'sd15440, 32'sd2372, 32'sd865};
	localparam sample_t b0 [fiber_count] = '{32'sd3965, 32'sd5387, 32'sd5387};
	localparam sample_t f_coef [fiber_count] = '{32'sd1894, 32'sd4168, 32'sd6252};
	// chain shares the bag2 stiffness
	localparam sample_t ksr_kpr [fiber_count] = '{32'sd693214, 32'sd696464, 32'sd696464};
	localparam sample_t ia_gain [fiber_count] = '{32'sd131072000, 32'sd65536000, 32'sd65536000};

	localparam sample_t ksr = 32'sd685828;
	localparam sample_t inv_mass = 32'sd327680000;
	localparam sample_t ksr_lsr0 = 32'sd27433;
	localparam sample_t kpr_lpr0 = 32'sd5613;
	localparam sample_t lsr0 = 32'sd2621;
	localparam sample_t rldfv = 32'sd30147;
	localparam sample_t x1_reset = 32'sd62777;
	localparam sample_t ii_gain = 32'sd47513600;
	localparam sample_t c0 = 32'sd45875;
	localparam sample_t c3 = 32'sd1035;
	localparam sample_t c6 = 32'sd62915;
	localparam sample_t ia_minor_weight = 32'sd10224;
	localparam sample_t rate_max = 32'sd655360000;

	// double width product, rescaled but not yet truncated
	function automatic logic signed [63:0] fx_mul_wide(input sample_t a, input sample_t b);
		logic signed [63:0] prod;
		prod = 64'(a) * 64'(b);
		return prod >>> frac_bits;
	endfunction

	function automatic sample_t fx_mul(input sample_t a, input sample_t b);
		logic signed [63:0] wide;
		wide = fx_mul_wide(a, b);
		return wide[31:0];
	endfunction

endpackage
